/* flist.f */
verilog/rename_pkg.sv
verilog/rename_decode.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/reorder_buffer.sv
verilog/rename_top.sv
testbench/tb_rename.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the rename testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_rename -Mdir "$build_dir" -f flist.f

# a fatal check ends the binary with a nonzero status, the log decides
"./$build_dir/Vtb_rename" > "$log_file" 2>&1 || true
cat "$log_file"

if grep -q "STATUS: FAIL" "$log_file"; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "STATUS: PASS" "$log_file"; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

/* testbench/tb_rename.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rename
  import rename_pkg::*;
();

  localparam int rob_depth = 64;
  localparam logic [31:0] seed = 32'h9f55_efe5;

  typedef struct packed {
    logic       dispatch;
    inst_t      slot0;
    inst_t      slot1;
    logic [1:0] completions;
    logic       flush;
  } step_t;

  typedef struct packed {
    rob_idx_t  idx;
    arch_idx_t dest;
    pr_idx_t   pdest;
    pr_idx_t   told;
    logic      done;
  } rob_entry_t;

  logic                     clock;
  logic                     reset;
  logic                     dispatch_en;
  inst_t    [num_super-1:0] inst_in;
  logic     [num_super-1:0] complete_en;
  rob_idx_t [num_super-1:0] complete_idx;
  logic                     flush;
  logic                     dispatch_ready;
  renamed_t [num_super-1:0] renamed_out;
  retire_t  [num_super-1:0] retire_out;

  // reference model state
  step_t      steps[$];
  pr_idx_t    fl_q[$];
  pr_idx_t    spec_map [num_arch];
  pr_idx_t    arch_map [num_arch];
  rob_entry_t rob_q[$];
  rob_idx_t   pending[$];
  int         rob_tail;
  logic [31:0] rng_state;
  int         cycles = 0;
  int         cycle_limit = 0;

  rename_top #(
    .rob_depth (rob_depth)
  ) dut0 (
    .clock          (clock),
    .reset          (reset),
    .dispatch_en    (dispatch_en),
    .inst_in        (inst_in),
    .complete_en    (complete_en),
    .complete_idx   (complete_idx),
    .flush          (flush),
    .dispatch_ready (dispatch_ready),
    .renamed_out    (renamed_out),
    .retire_out     (retire_out)
  );

  always #4 clock = ~clock;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      fail_run($sformatf("timeout: the run did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic check_renamed(input string name, input renamed_t got, input renamed_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_retired(input string name, input retire_t got, input retire_t exp);
    if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
      fail_run($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_ready(input string name, input bit got, input bit exp);
    if (got != exp) begin
      fail_run($sformatf("FAIL %0t %s got %0b expected %0b", $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic inst_t make_inst(input op_kind_t op, input int dest,
                                      input int src1, input int src2);
    inst_t inst;
    inst.valid = 1'b1;
    inst.op    = op;
    inst.dest  = arch_idx_t'(dest);
    inst.src1  = arch_idx_t'(src1);
    inst.src2  = arch_idx_t'(src2);
    return inst;
  endfunction

  task automatic add_step(input bit dispatch, input inst_t slot0, input inst_t slot1,
                          input int completions, input bit do_flush);
    step_t s;
    s.dispatch    = dispatch;
    s.slot0       = slot0;
    s.slot1       = slot1;
    s.completions = 2'(completions);
    s.flush       = do_flush;
    steps.push_back(s);
  endtask

  task automatic build_table();
    inst_t nop;
    nop = '0;
    // single destinations right after reset
    add_step(1'b1, make_inst(alu, 1, 10, 11), nop, 0, 1'b0);
    add_step(1'b1, make_inst(load, 2, 12, 0), nop, 0, 1'b0);
    add_step(1'b1, nop, make_inst(alu, 3, 13, 14), 0, 1'b0);
    // forwarding inside the pair, kinds without destination, a repeated destination
    add_step(1'b1, make_inst(alu, 4, 1, 2), make_inst(alu, 5, 4, 4), 0, 1'b0);
    add_step(1'b1, make_inst(store, 7, 4, 5), make_inst(branch, 0, 5, 1), 0, 1'b0);
    add_step(1'b1, make_inst(alu, 0, 3, 3), make_inst(load, 6, 0, 2), 0, 1'b0);
    add_step(1'b1, make_inst(alu, 8, 1, 2), make_inst(load, 8, 8, 6), 0, 1'b0);
    // twelve more pairs use up all 32 free registers
    for (int k = 0; k < 12; k++) begin
      add_step(1'b1, make_inst(alu, 9 + k, k, 31 - k),
               make_inst(load, 20 + (k % 11), 9 + k, k + 1), 0, 1'b0);
    end
    // with the list empty only groups without a destination go through
    add_step(1'b1, make_inst(alu, 1, 2, 3), nop, 0, 1'b0);
    add_step(1'b1, make_inst(store, 1, 2, 3), make_inst(branch, 4, 5, 6), 0, 1'b0);
    add_step(1'b1, make_inst(alu, 0, 9, 9), make_inst(load, 5, 1, 1), 0, 1'b0);
    for (int k = 0; k < 16; k++) begin
      add_step(1'b0, nop, nop, 2, 1'b0);
    end
    // these allocations take the told registers in the order they retired
    for (int k = 0; k < 6; k++) begin
      add_step(1'b1, make_inst(alu, 2 + k, 8, 20), make_inst(load, 12 + k, 2 + k, 3), 1, 1'b0);
    end
    add_step(1'b0, nop, nop, 1, 1'b1);
    add_step(1'b1, make_inst(alu, 9, 2, 12), make_inst(alu, 10, 9, 30), 0, 1'b0);
    add_step(1'b1, make_inst(load, 11, 20, 25), nop, 2, 1'b0);
    add_step(1'b0, nop, nop, 1, 1'b0);
    add_step(1'b0, nop, nop, 0, 1'b1);
    // a flush with nothing in flight leaves the free list alone
    add_step(1'b0, nop, nop, 0, 1'b1);
    add_step(1'b1, make_inst(alu, 13, 9, 11), make_inst(alu, 14, 13, 13), 2, 1'b0);
  endtask

  task automatic apply_step(input step_t s);
    inst_t      [num_super-1:0] slot;
    renamed_t   [num_super-1:0] exp_ren;
    retire_t    [num_super-1:0] exp_ret;
    logic       [num_super-1:0] writes;
    logic       [num_super-1:0] comp_en;
    rob_idx_t   [num_super-1:0] comp_idx;
    rob_entry_t                 ent;
    int                         ndest;
    int                         j;
    bit                         exp_ready;

    slot = '0;
    if (s.dispatch) begin
      slot[0] = s.slot0;
      slot[1] = s.slot1;
    end
    comp_en  = '0;
    comp_idx = '0;
    // completions pick random entries among those still outstanding
    for (int k = 0; k < num_super; k++) begin
      if (k < int'(s.completions) && pending.size() > 0) begin
        rng_state   = next_random(rng_state);
        j           = int'(rng_state % 32'(pending.size()));
        comp_idx[k] = pending[j];
        comp_en[k]  = 1'b1;
        pending.delete(j);
      end
    end

    @(negedge clock);
    dispatch_en  = s.dispatch;
    inst_in      = slot;
    complete_en  = comp_en;
    complete_idx = comp_idx;
    flush        = s.flush;
    #1;

    ndest = 0;
    for (int i = 0; i < num_super; i++) begin
      writes[i] = slot[i].valid && (slot[i].op == alu || slot[i].op == load) &&
                  (slot[i].dest != zero_reg);
      exp_ren[i]       = '0;
      exp_ren[i].valid = slot[i].valid;
      if (writes[i]) begin
        if (ndest < fl_q.size()) begin
          exp_ren[i].pdest = fl_q[ndest];
        end
        ndest++;
      end
      exp_ren[i].psrc1 = spec_map[slot[i].src1];
      exp_ren[i].psrc2 = spec_map[slot[i].src2];
      exp_ren[i].told  = writes[i] ? spec_map[slot[i].dest] : zero_pr;
    end
    exp_ren[0].rob_idx = rob_idx_t'(rob_tail);
    exp_ren[1].rob_idx = rob_idx_t'((rob_tail + int'(slot[0].valid)) % rob_depth);
    // slot 1 is younger and sees slot 0's new mapping
    if (writes[0]) begin
      if (slot[1].src1 == slot[0].dest) begin
        exp_ren[1].psrc1 = exp_ren[0].pdest;
      end
      if (slot[1].src2 == slot[0].dest) begin
        exp_ren[1].psrc2 = exp_ren[0].pdest;
      end
      if (writes[1] && slot[1].dest == slot[0].dest) begin
        exp_ren[1].told = exp_ren[0].pdest;
      end
    end

    exp_ready = (fl_q.size() >= ndest) && (rob_q.size() <= rob_depth - num_super);
    check_ready("dispatch_ready", dispatch_ready, exp_ready);
    if (exp_ready) begin
      for (int i = 0; i < num_super; i++) begin
        check_renamed($sformatf("renamed_out[%0d]", i), renamed_out[i], exp_ren[i]);
      end
    end

    for (int i = 0; i < num_super; i++) begin
      exp_ret[i] = '0;
      if (i < rob_q.size() && rob_q[i].done && (i == 0 || exp_ret[0].valid)) begin
        exp_ret[i].valid = 1'b1;
        exp_ret[i].dest  = rob_q[i].dest;
        exp_ret[i].pdest = rob_q[i].pdest;
        exp_ret[i].told  = rob_q[i].told;
      end
      check_retired($sformatf("retire_out[%0d]", i), retire_out[i], exp_ret[i]);
    end

    // what the rising edge does, retirement first
    for (int i = 0; i < num_super; i++) begin
      if (exp_ret[i].valid) begin
        ent = rob_q.pop_front();
        if (ent.dest != zero_reg) begin
          arch_map[ent.dest] = ent.pdest;
        end
        if (ent.told != zero_pr) begin
          fl_q.push_back(ent.told);
        end
      end
    end
    if (s.flush) begin
      // squashed destinations return ahead of the registers already free
      for (int k = rob_q.size() - 1; k >= 0; k--) begin
        if (rob_q[k].pdest != zero_pr) begin
          fl_q.push_front(rob_q[k].pdest);
        end
      end
      rob_q.delete();
      pending.delete();
      spec_map = arch_map;
      rob_tail = 0;
    end else begin
      for (int k = 0; k < rob_q.size(); k++) begin
        ent = rob_q[k];
        for (int i = 0; i < num_super; i++) begin
          if (comp_en[i] && ent.idx == comp_idx[i]) begin
            ent.done = 1'b1;
          end
        end
        rob_q[k] = ent;
      end
      if (s.dispatch && exp_ready) begin
        for (int i = 0; i < num_super; i++) begin
          if (slot[i].valid) begin
            ent.idx   = exp_ren[i].rob_idx;
            ent.dest  = writes[i] ? slot[i].dest : zero_reg;
            ent.pdest = exp_ren[i].pdest;
            ent.told  = exp_ren[i].told;
            ent.done  = 1'b0;
            rob_q.push_back(ent);
            pending.push_back(ent.idx);
            if (writes[i]) begin
              fl_q.delete(0);
              spec_map[slot[i].dest] = exp_ren[i].pdest;
            end
            rob_tail = (rob_tail + 1) % rob_depth;
          end
        end
      end
    end
  endtask

  initial begin
    step_t drain;

    clock        = 1'b0;
    reset        = 1'b1;
    dispatch_en  = 1'b0;
    inst_in      = '0;
    complete_en  = '0;
    complete_idx = '0;
    flush        = 1'b0;
    rng_state    = seed;
    rob_tail     = 0;
    for (int i = 0; i < num_fl; i++) begin
      fl_q.push_back(pr_idx_t'(num_fl + i));
    end
    for (int i = 0; i < num_arch; i++) begin
      spec_map[i] = pr_idx_t'(i);
      arch_map[i] = pr_idx_t'(i);
    end
    build_table();
    cycle_limit = steps.size() * 4 + 100;

    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    foreach (steps[n]) begin
      apply_step(steps[n]);
    end
    // everything still in flight completes and retires
    drain = '0;
    drain.completions = 2'd2;
    while (rob_q.size() > 0) begin
      apply_step(drain);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list
  import rename_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      alloc_en,
  input  logic    [num_super-1:0]   has_dest,
  input  logic                      rollback_en,
  input  fl_idx_t                   rollback_pos,
  input  logic    [num_super-1:0]   free_en,
  input  pr_idx_t [num_super-1:0]   free_told,
  output alloc_t  [num_super-1:0]   grant,
  output logic                      fl_ready
);

  localparam int cnt_w = $clog2(num_fl + 1);
  localparam int grp_w = $clog2(num_super + 1);

  pr_idx_t [num_fl-1:0]    fl_table;
  fl_idx_t                 head;
  fl_idx_t                 tail;
  fl_idx_t                 next_head;
  fl_idx_t                 next_tail;
  fl_idx_t                 alloc_pos;
  fl_idx_t [num_super-1:0] free_pos;
  logic    [num_super-1:0] do_free;
  logic    [grp_w-1:0]     num_alloc;
  logic    [grp_w-1:0]     num_free;
  logic    [cnt_w-1:0]     free_count;
  logic    [cnt_w-1:0]     next_count;

  // allocation walks up from the tail, one slot per destination
  always_comb begin
    alloc_pos = tail;
    num_alloc = '0;
    for (int i = 0; i < num_super; i++) begin
      grant[i].pdest  = has_dest[i] ? fl_table[alloc_pos] : zero_pr;
      alloc_pos       = alloc_pos + fl_idx_t'(has_dest[i]);
      grant[i].fl_pos = alloc_pos;
      num_alloc       = num_alloc + grp_w'(has_dest[i]);
    end
  end

  // the count tells a full list from an empty one when head equals tail
  assign fl_ready = free_count >= cnt_w'(num_alloc);

  always_comb begin
    next_head = head;
    num_free  = '0;
    for (int i = 0; i < num_super; i++) begin
      do_free[i]  = free_en[i] && (free_told[i] != zero_pr);
      free_pos[i] = next_head;
      next_head   = next_head + fl_idx_t'(do_free[i]);
      num_free    = num_free + grp_w'(do_free[i]);
    end
  end

  always_comb begin
    next_tail  = tail;
    next_count = free_count + cnt_w'(num_free);
    if (rollback_en) begin
      // every squashed destination comes back, so the list is full again
      next_tail  = rollback_pos;
      next_count = cnt_w'(num_fl);
    end else if (alloc_en) begin
      next_tail  = alloc_pos;
      next_count = next_count - cnt_w'(num_alloc);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head       <= '0;
      tail       <= '0;
      free_count <= cnt_w'(num_fl);
      for (int i = 0; i < num_fl; i++) begin
        fl_table[i] <= pr_idx_t'(num_fl + i);
      end
    end else begin
      head       <= next_head;
      tail       <= next_tail;
      free_count <= next_count;
      for (int i = 0; i < num_super; i++) begin
        if (do_free[i]) begin
          fl_table[free_pos[i]] <= free_told[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/map_table.sv */
`timescale 1ns/1ps
`default_nettype none

module map_table
  import rename_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       rename_en,
  input  decoded_t [num_super-1:0]   dec_in,
  input  pr_idx_t  [num_super-1:0]   pdest,
  input  retire_t  [num_super-1:0]   commit,
  input  logic                       restore,
  output pr_idx_t  [num_super-1:0]   psrc1,
  output pr_idx_t  [num_super-1:0]   psrc2,
  output pr_idx_t  [num_super-1:0]   told
);

  pr_idx_t [num_arch-1:0] spec_map;
  pr_idx_t [num_arch-1:0] arch_map;
  pr_idx_t [num_arch-1:0] next_arch;

  // lookups read the speculative table, with slot 0's new pdest bypassed to slot 1
  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      psrc1[i] = dec_in[i].fwd1 ? pdest[0] : spec_map[dec_in[i].src1];
      psrc2[i] = dec_in[i].fwd2 ? pdest[0] : spec_map[dec_in[i].src2];
      if (!dec_in[i].has_dest) begin
        told[i] = zero_pr;
      end else if (dec_in[i].fwd_dest) begin
        told[i] = pdest[0];
      end else begin
        told[i] = spec_map[dec_in[i].dest];
      end
    end
  end

  // retirement in program order, so the younger slot is applied last
  always_comb begin
    next_arch = arch_map;
    for (int i = 0; i < num_super; i++) begin
      if (commit[i].valid && (commit[i].dest != zero_reg)) begin
        next_arch[commit[i].dest] = commit[i].pdest;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_arch; i++) begin
        spec_map[i] <= pr_idx_t'(i);
        arch_map[i] <= pr_idx_t'(i);
      end
    end else begin
      arch_map <= next_arch;
      if (restore) begin
        spec_map <= next_arch;
      end else if (rename_en) begin
        for (int i = 0; i < num_super; i++) begin
          if (dec_in[i].has_dest) begin
            spec_map[dec_in[i].dest] <= pdest[i];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/rename_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_decode
  import rename_pkg::*;
(
  input  inst_t    [num_super-1:0] inst_in,
  output decoded_t [num_super-1:0] dec_out
);

  logic [num_super-1:0] writes;

  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      writes[i] = inst_in[i].op inside {alu, load};

      dec_out[i].valid    = inst_in[i].valid;
      dec_out[i].has_dest = inst_in[i].valid && writes[i] && (inst_in[i].dest != zero_reg);
      // a slot that does not write reports register 0 as its destination
      dec_out[i].dest     = dec_out[i].has_dest ? inst_in[i].dest : zero_reg;
      dec_out[i].src1     = inst_in[i].src1;
      dec_out[i].src2     = inst_in[i].src2;
      dec_out[i].fwd1     = 1'b0;
      dec_out[i].fwd2     = 1'b0;
      dec_out[i].fwd_dest = 1'b0;
    end

    // slot 1 is younger, so it sees slot 0's new mapping
    dec_out[1].fwd1     = dec_out[0].has_dest && (inst_in[1].src1 == dec_out[0].dest);
    dec_out[1].fwd2     = dec_out[0].has_dest && (inst_in[1].src2 == dec_out[0].dest);
    dec_out[1].fwd_dest = dec_out[0].has_dest && dec_out[1].has_dest &&
                          (dec_out[1].dest == dec_out[0].dest);
  end

endmodule

`default_nettype wire

/* verilog/rename_pkg.sv */
`default_nettype none

package rename_pkg;

  // group width is fixed by the dispatch datapath
  localparam int num_super = 2;

  localparam int num_arch = 32;
  localparam int num_pr   = 64;
  localparam int num_fl   = 32;

  typedef logic [$clog2(num_arch)-1:0] arch_idx_t;
  typedef logic [$clog2(num_pr)-1:0]   pr_idx_t;
  typedef logic [$clog2(num_fl)-1:0]   fl_idx_t;

  // wide enough for any reorder buffer up to 256 entries
  typedef logic [7:0] rob_idx_t;

  localparam arch_idx_t zero_reg = '0;
  localparam pr_idx_t   zero_pr  = '0;

  // only alu and load write a destination register
  typedef enum logic [1:0] {
    alu    = 2'd0,
    load   = 2'd1,
    store  = 2'd2,
    branch = 2'd3
  } op_kind_t;

  typedef struct packed {
    logic      valid;
    op_kind_t  op;
    arch_idx_t dest;
    arch_idx_t src1;
    arch_idx_t src2;
  } inst_t;

  // fwd1/fwd2 mark slot 1 sources that read slot 0's destination,
  // fwd_dest marks both slots writing the same register
  typedef struct packed {
    logic      valid;
    logic      has_dest;
    arch_idx_t dest;
    arch_idx_t src1;
    arch_idx_t src2;
    logic      fwd1;
    logic      fwd2;
    logic      fwd_dest;
  } decoded_t;

  typedef struct packed {
    pr_idx_t pdest;
    fl_idx_t fl_pos;
  } alloc_t;

  typedef struct packed {
    logic     valid;
    pr_idx_t  pdest;
    pr_idx_t  psrc1;
    pr_idx_t  psrc2;
    pr_idx_t  told;
    rob_idx_t rob_idx;
  } renamed_t;

  typedef struct packed {
    logic      valid;
    arch_idx_t dest;
    pr_idx_t   pdest;
    pr_idx_t   told;
  } retire_t;

endpackage

`default_nettype wire

/* verilog/rename_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_top
  import rename_pkg::*;
#(
  parameter int rob_depth = 16
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       dispatch_en,
  input  inst_t    [num_super-1:0]   inst_in,
  input  logic     [num_super-1:0]   complete_en,
  input  rob_idx_t [num_super-1:0]   complete_idx,
  input  logic                       flush,
  output logic                       dispatch_ready,
  output renamed_t [num_super-1:0]   renamed_out,
  output retire_t  [num_super-1:0]   retire_out
);

  decoded_t [num_super-1:0] dec;
  alloc_t   [num_super-1:0] grant;
  logic     [num_super-1:0] has_dest;
  logic     [num_super-1:0] free_en;
  pr_idx_t  [num_super-1:0] pdest;
  pr_idx_t  [num_super-1:0] psrc1;
  pr_idx_t  [num_super-1:0] psrc2;
  pr_idx_t  [num_super-1:0] told;
  pr_idx_t  [num_super-1:0] free_told;
  fl_idx_t  [num_super-1:0] fl_pos;
  retire_t  [num_super-1:0] entry_in;
  rob_idx_t [num_super-1:0] rob_idx;
  fl_idx_t                  flush_fl_pos;
  logic                     flush_has_entry;
  logic                     fl_ready;
  logic                     rob_ready;
  logic                     accept;

  assign dispatch_ready = fl_ready & rob_ready;
  // flush wins over a dispatch in the same cycle
  assign accept = dispatch_en & dispatch_ready & ~flush;

  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      has_dest[i]  = dec[i].has_dest;
      pdest[i]     = grant[i].pdest;
      fl_pos[i]    = grant[i].fl_pos;
      free_en[i]   = retire_out[i].valid;
      free_told[i] = retire_out[i].told;

      entry_in[i].valid = dec[i].valid;
      entry_in[i].dest  = dec[i].dest;
      entry_in[i].pdest = grant[i].pdest;
      entry_in[i].told  = told[i];

      renamed_out[i].valid   = dec[i].valid;
      renamed_out[i].pdest   = grant[i].pdest;
      renamed_out[i].psrc1   = psrc1[i];
      renamed_out[i].psrc2   = psrc2[i];
      renamed_out[i].told    = told[i];
      renamed_out[i].rob_idx = rob_idx[i];
    end
  end

  rename_decode u_decode (
    .inst_in (inst_in),
    .dec_out (dec)
  );

  free_list u_free_list (
    .clock        (clock),
    .reset        (reset),
    .alloc_en     (accept),
    .has_dest     (has_dest),
    .rollback_en  (flush_has_entry),
    .rollback_pos (flush_fl_pos),
    .free_en      (free_en),
    .free_told    (free_told),
    .grant        (grant),
    .fl_ready     (fl_ready)
  );

  map_table u_map_table (
    .clock     (clock),
    .reset     (reset),
    .rename_en (accept),
    .dec_in    (dec),
    .pdest     (pdest),
    .commit    (retire_out),
    .restore   (flush),
    .psrc1     (psrc1),
    .psrc2     (psrc2),
    .told      (told)
  );

  reorder_buffer #(
    .rob_depth (rob_depth)
  ) u_rob (
    .clock           (clock),
    .reset           (reset),
    .dispatch_en     (accept),
    .entry_in        (entry_in),
    .fl_pos_in       (fl_pos),
    .complete_en     (complete_en),
    .complete_idx    (complete_idx),
    .flush           (flush),
    .rob_ready       (rob_ready),
    .rob_idx         (rob_idx),
    .retire_out      (retire_out),
    .flush_fl_pos    (flush_fl_pos),
    .flush_has_entry (flush_has_entry)
  );

endmodule

`default_nettype wire

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
  import rename_pkg::*;
#(
  parameter int rob_depth = 16
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       dispatch_en,
  input  retire_t  [num_super-1:0]   entry_in,
  input  fl_idx_t  [num_super-1:0]   fl_pos_in,
  input  logic     [num_super-1:0]   complete_en,
  input  rob_idx_t [num_super-1:0]   complete_idx,
  input  logic                       flush,
  output logic                       rob_ready,
  output rob_idx_t [num_super-1:0]   rob_idx,
  output retire_t  [num_super-1:0]   retire_out,
  output fl_idx_t                    flush_fl_pos,
  output logic                       flush_has_entry
);

  // pointers wrap naturally, so rob_depth is a power of two
  localparam int idx_w = $clog2(rob_depth);
  localparam int cnt_w = $clog2(rob_depth + 1);

  typedef logic [idx_w-1:0] ptr_t;

  retire_t              entry  [rob_depth];
  fl_idx_t              fl_pos [rob_depth];
  logic [rob_depth-1:0] done;

  ptr_t                 head;
  ptr_t                 tail;
  ptr_t                 next_tail;
  ptr_t                 oldest;
  ptr_t [num_super-1:0] alloc_ptr;
  ptr_t [num_super-1:0] retire_ptr;
  logic [num_super-1:0] retire_en;
  logic                 in_order;
  logic [cnt_w-1:0]     count;
  logic [cnt_w-1:0]     num_alloc;
  logic [cnt_w-1:0]     num_retire;

  assign rob_ready = count <= cnt_w'(rob_depth - num_super);

  // valid slots take consecutive entries starting at the tail
  always_comb begin
    next_tail = tail;
    num_alloc = '0;
    for (int i = 0; i < num_super; i++) begin
      alloc_ptr[i] = next_tail;
      rob_idx[i]   = rob_idx_t'(next_tail);
      next_tail    = next_tail + ptr_t'(entry_in[i].valid);
      num_alloc    = num_alloc + cnt_w'(entry_in[i].valid);
    end
  end

  // an entry retires only when it and everything older are complete
  always_comb begin
    in_order   = 1'b1;
    num_retire = '0;
    for (int i = 0; i < num_super; i++) begin
      retire_ptr[i]       = head + ptr_t'(i);
      retire_en[i]        = in_order && (count > cnt_w'(i)) && done[retire_ptr[i]];
      in_order            = retire_en[i];
      retire_out[i]       = entry[retire_ptr[i]];
      retire_out[i].valid = retire_en[i];
      num_retire          = num_retire + cnt_w'(retire_en[i]);
    end
  end

  // the oldest entry that survives this edge's retirement sets the rollback point
  assign oldest          = head + ptr_t'(num_retire);
  assign flush_has_entry = flush && (count > num_retire);
  assign flush_fl_pos    = fl_pos[oldest] - fl_idx_t'(entry[oldest].pdest != zero_pr);

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head <= oldest;
      if (dispatch_en) begin
        tail  <= next_tail;
        count <= count + num_alloc - num_retire;
      end else begin
        count <= count - num_retire;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= '0;
    end else if (flush) begin
      done <= '0;
    end else begin
      for (int i = 0; i < num_super; i++) begin
        if (complete_en[i]) begin
          done[complete_idx[i][idx_w-1:0]] <= 1'b1;
        end
      end
      if (dispatch_en) begin
        for (int i = 0; i < num_super; i++) begin
          if (entry_in[i].valid) begin
            done[alloc_ptr[i]] <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch_en && !flush) begin
      for (int i = 0; i < num_super; i++) begin
        if (entry_in[i].valid) begin
          entry[alloc_ptr[i]]  <= entry_in[i];
          fl_pos[alloc_ptr[i]] <= fl_pos_in[i];
        end
      end
    end
  end

endmodule

`default_nettype wire
